// ==== hdl/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Data and byte-address width of the core
`define MEM_XLEN 32

// SRAM depth in 32-bit words
`define MEM_WORDS 256

// Word-address bits needed to index the SRAM
`define MEM_AW 8

`endif

// ==== hdl/wb_pkg.sv ====
`default_nettype none

`include "mem_defines.svh"

package wb_pkg;

  // Request from a Wishbone master; adr is a word address
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [3:0]            sel;
    logic [`MEM_XLEN-3:0]  adr;
    logic [`MEM_XLEN-1:0]  dat;
  } wb_req_t;

  // Response from a slave
  typedef struct packed {
    logic                  ack;
    logic                  err;
    logic [`MEM_XLEN-1:0]  dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

`include "mem_defines.svh"

package lsu_pkg;

  // Encoding 3 is not named and decodes as a byte access
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

  // Load/store request coming from execute
  typedef struct packed {
    logic                  write;
    mem_size_e             size;
    logic [`MEM_XLEN-1:0]  addr;
    logic [`MEM_XLEN-1:0]  wdata;
  } mem_op_t;

endpackage

`default_nettype wire

// ==== hdl/wb_lane_steer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module wb_lane_steer (
  input  lsu_pkg::mem_size_e    size_i,
  input  logic [1:0]            byte_off_i,
  input  logic [`MEM_XLEN-1:0]  wdata_i,
  input  logic [`MEM_XLEN-1:0]  bus_rdata_i,
  output logic [3:0]            sel_o,
  output logic [`MEM_XLEN-1:0]  bus_wdata_o,
  output logic [`MEM_XLEN-1:0]  rdata_o
);

  import lsu_pkg::*;

  // Byte selects; a misaligned half falls onto its aligned lane pair
  always_comb begin
    case (size_i)
      SIZE_HALF: sel_o = byte_off_i[1] ? 4'b1100 : 4'b0011;
      SIZE_WORD: sel_o = 4'b1111;
      default:   sel_o = 4'b0001 << byte_off_i;
    endcase
  end

  // Replicate the low bytes across the bus, sel picks the lanes that land
  always_comb begin
    case (size_i)
      SIZE_HALF: bus_wdata_o = {2{wdata_i[15:0]}};
      SIZE_WORD: bus_wdata_o = wdata_i;
      default:   bus_wdata_o = {4{wdata_i[7:0]}};
    endcase
  end

  // Pull the addressed lanes down to bit 0, zero-extended
  always_comb begin
    case (size_i)
      SIZE_HALF: begin
        if (byte_off_i[1]) begin
          rdata_o = {{(`MEM_XLEN-16){1'b0}}, bus_rdata_i[31:16]};
        end else begin
          rdata_o = {{(`MEM_XLEN-16){1'b0}}, bus_rdata_i[15:0]};
        end
      end
      SIZE_WORD: rdata_o = bus_rdata_i;
      default:   rdata_o = {{(`MEM_XLEN-8){1'b0}}, bus_rdata_i[8*byte_off_i +: 8]};
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/mem_access_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_access_unit (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  op_valid_i,
  input  lsu_pkg::mem_op_t      op_i,
  output logic                  busy_o,
  output logic                  err_o,
  output logic [`MEM_XLEN-1:0]  rdata_o,
  output wb_pkg::wb_req_t       wb_req_o,
  input  wb_pkg::wb_rsp_t       wb_rsp_i
);

  import wb_pkg::*;
  import lsu_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_WAIT
  } state_e;

  state_e               state_q;
  wb_req_t              req_q;
  mem_size_e            size_q;
  logic [1:0]           off_q;

  mem_size_e            steer_size;
  logic [1:0]           steer_off;
  logic [3:0]           sel;
  logic [`MEM_XLEN-1:0] bus_wdata;
  logic [`MEM_XLEN-1:0] load_data;

  // Idle steers the incoming op, wait steers the one held on the bus
  assign steer_size = (state_q == ST_WAIT) ? size_q : op_i.size;
  assign steer_off  = (state_q == ST_WAIT) ? off_q : op_i.addr[1:0];

  wb_lane_steer u_wb_lane_steer (
    .size_i      (steer_size),
    .byte_off_i  (steer_off),
    .wdata_i     (op_i.wdata),
    .bus_rdata_i (wb_rsp_i.dat),
    .sel_o       (sel),
    .bus_wdata_o (bus_wdata),
    .rdata_o     (load_data)
  );

  assign wb_req_o = req_q;
  assign busy_o   = (state_q == ST_WAIT);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      req_q.cyc <= 1'b0;
      req_q.stb <= 1'b0;
      req_q.we  <= 1'b0;
      req_q.sel <= 4'b0000;
      err_o     <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (op_valid_i) begin
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
            req_q.we  <= op_i.write;
            req_q.sel <= sel;
            req_q.adr <= op_i.addr[`MEM_XLEN-1:2];
            req_q.dat <= bus_wdata;
            size_q    <= op_i.size;
            off_q     <= op_i.addr[1:0];
            err_o     <= 1'b0;
            state_q   <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          // Any response here means the arbiter has granted us
          if (wb_rsp_i.ack) begin
            if (!req_q.we) begin
              rdata_o <= load_data;
            end
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            req_q.we  <= 1'b0;
            state_q   <= ST_IDLE;
          end else if (wb_rsp_i.err) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            req_q.we  <= 1'b0;
            req_q.sel <= 4'b0000;
            err_o     <= 1'b1;
            state_q   <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wb_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_bus_arbiter (
  input  logic             clk_i,
  input  logic             reset_i,
  input  wb_pkg::wb_req_t  m0_req_i,
  output wb_pkg::wb_rsp_t  m0_rsp_o,
  input  wb_pkg::wb_req_t  m1_req_i,
  output wb_pkg::wb_rsp_t  m1_rsp_o,
  output wb_pkg::wb_req_t  s_req_o,
  input  wb_pkg::wb_rsp_t  s_rsp_i
);

  logic busy_q;
  logic owner_q;
  logic owner_cyc;
  logic locked;
  logic grant_m1;

  // Owner keeps the bus while its cyc is up, dropping cyc frees it at once
  assign owner_cyc = owner_q ? m1_req_i.cyc : m0_req_i.cyc;
  assign locked    = busy_q && owner_cyc;

  // Data side wins a tie on a free bus
  assign grant_m1 = locked ? owner_q : (!m0_req_i.cyc && m1_req_i.cyc);

  assign s_req_o = grant_m1 ? m1_req_i : m0_req_i;

  // The registered response belongs to the master granted on the last edge
  assign m0_rsp_o = '{
    ack: s_rsp_i.ack & ~owner_q,
    err: s_rsp_i.err & ~owner_q,
    dat: s_rsp_i.dat
  };
  assign m1_rsp_o = '{
    ack: s_rsp_i.ack & owner_q,
    err: s_rsp_i.err & owner_q,
    dat: s_rsp_i.dat
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      busy_q  <= s_req_o.cyc;
      owner_q <= grant_m1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wb_sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module wb_sram_slave (
  input  logic             clk_i,
  input  logic             reset_i,
  input  wb_pkg::wb_req_t  req_i,
  output wb_pkg::wb_rsp_t  rsp_o
);

  import wb_pkg::*;

  logic [3:0][7:0]    mem [`MEM_WORDS];
  wb_rsp_t            rsp_q;
  logic [`MEM_AW-1:0] word_idx;
  logic               in_range;
  logic               pending;
  logic               hit;

  assign word_idx = req_i.adr[`MEM_AW-1:0];
  assign in_range = (req_i.adr < `MEM_WORDS);

  // A response is still on the bus, so the held strobe is not a new cycle
  assign pending = rsp_q.ack | rsp_q.err;
  assign hit     = req_i.cyc & req_i.stb & ~pending;

  assign rsp_o = rsp_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_q.ack <= 1'b0;
      rsp_q.err <= 1'b0;
    end else begin
      rsp_q.ack <= hit & in_range;
      rsp_q.err <= hit & ~in_range;
    end
  end

  // Storage and read port
  always_ff @(posedge clk_i) begin
    if (hit && in_range) begin
      rsp_q.dat <= mem[word_idx];
      if (req_i.we) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (req_i.sel[lane]) begin
            mem[word_idx][lane] <= req_i.dat[8*lane +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module mem_subsystem_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  op_valid_i,
  input  lsu_pkg::mem_op_t      op_i,
  output logic                  busy_o,
  output logic                  err_o,
  output logic [`MEM_XLEN-1:0]  rdata_o,
  input  logic                  fetch_req_i,
  input  logic [`MEM_XLEN-1:0]  fetch_addr_i,
  output logic                  fetch_ack_o,
  output logic [`MEM_XLEN-1:0]  fetch_data_o
);

  import wb_pkg::*;

  wb_req_t data_req;
  wb_rsp_t data_rsp;
  wb_req_t fetch_req;
  wb_rsp_t fetch_rsp;
  wb_req_t sram_req;
  wb_rsp_t sram_rsp;

  // Fetch is always a full-word read
  assign fetch_req = '{
    cyc: fetch_req_i,
    stb: fetch_req_i,
    we:  1'b0,
    sel: 4'b1111,
    adr: fetch_addr_i[`MEM_XLEN-1:2],
    dat: '0
  };

  // An errored fetch still ends the handshake so the fetch side can drop its request
  assign fetch_ack_o  = fetch_rsp.ack | fetch_rsp.err;
  assign fetch_data_o = fetch_rsp.dat;

  mem_access_unit u_mem_access_unit (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .op_valid_i (op_valid_i),
    .op_i       (op_i),
    .busy_o     (busy_o),
    .err_o      (err_o),
    .rdata_o    (rdata_o),
    .wb_req_o   (data_req),
    .wb_rsp_i   (data_rsp)
  );

  wb_bus_arbiter u_wb_bus_arbiter (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .m0_req_i (data_req),
    .m0_rsp_o (data_rsp),
    .m1_req_i (fetch_req),
    .m1_rsp_o (fetch_rsp),
    .s_req_o  (sram_req),
    .s_rsp_i  (sram_rsp)
  );

  wb_sram_slave u_wb_sram_slave (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (sram_req),
    .rsp_o   (sram_rsp)
  );

endmodule

`default_nettype wire

// ==== verification/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_defines.svh"

module tb_mem_subsystem;

  import lsu_pkg::*;

  // About 140 bus operations of 2 to 8 cycles plus reset stay near 450 cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int OP_LIMIT       = 50;
  localparam int NUM_WORDS      = 16;

  logic                 clk_i;
  logic                 reset_i;
  logic                 op_valid_i;
  mem_op_t              op_i;
  logic                 busy_o;
  logic                 err_o;
  logic [`MEM_XLEN-1:0] rdata_o;
  logic                 fetch_req_i;
  logic [`MEM_XLEN-1:0] fetch_addr_i;
  logic                 fetch_ack_o;
  logic [`MEM_XLEN-1:0] fetch_data_o;

  // Byte image of the low words as accepted in-range stores leave them
  logic [7:0]  shadow [NUM_WORDS*4];
  logic [31:0] rng_state;
  int          value_errors;
  int          other_errors;
  int          op_cycles;
  int          cycle_count;

  mem_subsystem_top u_mem_subsystem_top (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .op_valid_i   (op_valid_i),
    .op_i         (op_i),
    .busy_o       (busy_o),
    .err_o        (err_o),
    .rdata_o      (rdata_o),
    .fetch_req_i  (fetch_req_i),
    .fetch_addr_i (fetch_addr_i),
    .fetch_ack_o  (fetch_ack_o),
    .fetch_data_o (fetch_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Lowest lane of an access; halves snap to their pair by offset bit 1
  function automatic int first_lane(mem_size_e size, logic [31:0] addr);
    if (size == SIZE_WORD) begin
      return 0;
    end
    if (size == SIZE_HALF) begin
      return {addr[1], 1'b0};
    end
    return addr[1:0];
  endfunction

  function automatic int lane_count(mem_size_e size);
    if (size == SIZE_WORD) begin
      return 4;
    end
    if (size == SIZE_HALF) begin
      return 2;
    end
    return 1;
  endfunction

  task automatic model_store(mem_size_e size, logic [31:0] addr, logic [31:0] wdata);
    int base;
    int i;
    base = int'(addr[31:2]) * 4 + first_lane(size, addr);
    for (i = 0; i < lane_count(size); i++) begin
      shadow[base + i] = wdata[8*i +: 8];
    end
  endtask

  // Loads come back right-aligned and zero-extended
  function automatic logic [31:0] expected_load(mem_size_e size, logic [31:0] addr);
    logic [31:0] value;
    int          base;
    int          i;
    value = '0;
    base  = int'(addr[31:2]) * 4 + first_lane(size, addr);
    for (i = 0; i < lane_count(size); i++) begin
      value[8*i +: 8] = shadow[base + i];
    end
    return value;
  endfunction

  task automatic report_mismatch(string test, logic [31:0] expected, logic [31:0] actual);
    value_errors++;
    $display("[FAIL] %s: expected %h, actual %h", test, expected, actual);
  endtask

  task automatic report_problem(string what);
    other_errors++;
    $display("Error: %s", what);
  endtask

  task automatic issue_op(logic write, mem_size_e size, logic [31:0] addr,
                          logic [31:0] wdata);
    op_i.write = write;
    op_i.size  = size;
    op_i.addr  = addr;
    op_i.wdata = wdata;
    op_valid_i = 1'b1;
  endtask

  // op_valid_i drops after the first edge, then count until busy_o falls
  task automatic wait_not_busy();
    op_cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      op_valid_i = 1'b0;
      op_cycles++;
    end while (busy_o && op_cycles < OP_LIMIT);
    if (busy_o) begin
      report_problem("busy_o stayed high, the data access never finished");
    end
  endtask

  task automatic store_and_model(mem_size_e size, logic [31:0] addr, logic [31:0] wdata);
    issue_op(1'b1, size, addr, wdata);
    wait_not_busy();
    model_store(size, addr, wdata);
  endtask

  task automatic load_and_check(string test, mem_size_e size, logic [31:0] addr);
    logic [31:0] expected;
    expected = expected_load(size, addr);
    issue_op(1'b0, size, addr, '0);
    wait_not_busy();
    if (rdata_o !== expected) begin
      report_mismatch(test, expected, rdata_o);
    end
  endtask

  task automatic fetch_and_check(string test, logic [31:0] addr);
    logic [31:0] expected;
    int          cycles;
    expected     = expected_load(SIZE_WORD, addr);
    fetch_addr_i = addr;
    fetch_req_i  = 1'b1;
    cycles       = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
    end while (!fetch_ack_o && cycles < OP_LIMIT);
    if (!fetch_ack_o) begin
      report_problem("fetch_ack_o never arrived for a fetch read");
    end else if (fetch_data_o !== expected) begin
      report_mismatch(test, expected, fetch_data_o);
    end
    fetch_req_i = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  task automatic word_round_trip();
    logic [31:0] data;
    int          k;
    if (busy_o !== 1'b0 || err_o !== 1'b0 || fetch_ack_o !== 1'b0) begin
      report_problem("busy_o, err_o or fetch_ack_o is not low after reset");
    end
    for (k = 0; k < NUM_WORDS; k++) begin
      data = next_random();
      store_and_model(SIZE_WORD, k * 4, data);
      if (op_cycles != 3) begin
        report_mismatch("word store latency", 3, op_cycles);
      end
    end
    for (k = 0; k < NUM_WORDS; k++) begin
      load_and_check("word load", SIZE_WORD, k * 4);
      if (op_cycles != 3) begin
        report_mismatch("word load latency", 3, op_cycles);
      end
    end
  endtask

  task automatic byte_lane_stores();
    int word;
    int n;
    int off;
    for (n = 0; n < 4; n++) begin
      word = next_random() % NUM_WORDS;
      for (off = 0; off < 4; off++) begin
        store_and_model(SIZE_BYTE, word * 4 + off, next_random());
        load_and_check("byte load", SIZE_BYTE, word * 4 + off);
        load_and_check("word after byte store", SIZE_WORD, word * 4);
      end
    end
  endtask

  task automatic half_lane_stores();
    int word;
    int n;
    int off;
    for (n = 0; n < 4; n++) begin
      word = next_random() % NUM_WORDS;
      for (off = 0; off < 4; off += 2) begin
        store_and_model(SIZE_HALF, word * 4 + off, next_random());
        load_and_check("half load", SIZE_HALF, word * 4 + off);
        load_and_check("word after half store", SIZE_WORD, word * 4);
      end
    end
  endtask

  task automatic out_of_range_access();
    logic [31:0] bad_addr;
    int          k;
    k = next_random() % NUM_WORDS;
    // Low address bits alias onto word k, so a stray write would show there
    bad_addr = (`MEM_WORDS + k) * 4;
    issue_op(1'b1, SIZE_WORD, bad_addr, ~expected_load(SIZE_WORD, k * 4));
    wait_not_busy();
    if (err_o !== 1'b1) begin
      report_problem("err_o not set after a store past the end of memory");
    end
    @(posedge clk_i);
    #1;
    if (err_o !== 1'b1) begin
      report_problem("err_o dropped before the next op was accepted");
    end
    load_and_check("aliased word after bad store", SIZE_WORD, k * 4);
    if (err_o !== 1'b0) begin
      report_problem("err_o not cleared by the next accepted op");
    end
    issue_op(1'b0, SIZE_BYTE, 32'h8000_0000 + k * 4, '0);
    wait_not_busy();
    if (err_o !== 1'b1) begin
      report_problem("err_o not set after a load past the end of memory");
    end
    load_and_check("load after bad load", SIZE_BYTE, k * 4 + 3);
    if (err_o !== 1'b0) begin
      report_problem("err_o not cleared after the bad load");
    end
  endtask

  // Raised on the same edge, the fetch cyc reaches the arbiter a cycle before the
  // registered data cyc; a one-cycle lag puts both on the arbiter at once
  task automatic contend(logic fetch_lags);
    logic [31:0] data_addr;
    logic [31:0] fetch_addr;
    logic [31:0] data_exp;
    logic [31:0] fetch_exp;
    int          cycles;
    int          data_done_at;
    int          fetch_done_at;
    data_addr     = (next_random() % NUM_WORDS) * 4;
    fetch_addr    = (next_random() % NUM_WORDS) * 4;
    data_exp      = expected_load(SIZE_WORD, data_addr);
    fetch_exp     = expected_load(SIZE_WORD, fetch_addr);
    data_done_at  = 0;
    fetch_done_at = 0;
    cycles        = 0;
    fetch_addr_i  = fetch_addr;
    issue_op(1'b0, SIZE_WORD, data_addr, '0);
    fetch_req_i = !fetch_lags;
    while ((data_done_at == 0 || fetch_done_at == 0) && cycles < OP_LIMIT) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (data_done_at == 0 && !busy_o) begin
        data_done_at = cycles;
        if (rdata_o !== data_exp) begin
          report_mismatch("load under fetch contention", data_exp, rdata_o);
        end
      end
      if (fetch_done_at == 0 && fetch_ack_o) begin
        fetch_done_at = cycles;
        if (fetch_data_o !== fetch_exp) begin
          report_mismatch("fetch under data contention", fetch_exp, fetch_data_o);
        end
        fetch_req_i = 1'b0;
      end
      if (cycles == 1) begin
        op_valid_i = 1'b0;
        if (fetch_lags) begin
          fetch_req_i = 1'b1;
        end
      end
    end
    if (data_done_at == 0 || fetch_done_at == 0) begin
      report_problem("an access under contention never finished");
    end else if (fetch_lags && data_done_at >= fetch_done_at) begin
      report_problem("fetch finished before the data access on a tie at the arbiter");
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic fetch_reads();
    int n;
    for (n = 0; n < 8; n++) begin
      fetch_and_check("fetch read", (next_random() % NUM_WORDS) * 4);
    end
    contend(1'b0);
    contend(1'b1);
  endtask

  task automatic busy_pulse_drops();
    logic [31:0] data;
    int          a;
    int          b;
    a    = next_random() % NUM_WORDS;
    b    = (a + 1) % NUM_WORDS;
    data = next_random();
    issue_op(1'b1, SIZE_WORD, a * 4, data);
    @(posedge clk_i);
    #1;
    if (busy_o !== 1'b1) begin
      report_problem("busy_o not high the cycle after an accepted op");
    end
    // Second store arrives while the first one is still on the bus
    issue_op(1'b1, SIZE_WORD, b * 4, ~data);
    wait_not_busy();
    model_store(SIZE_WORD, a * 4, data);
    load_and_check("store before ignored pulse", SIZE_WORD, a * 4);
    load_and_check("word behind ignored pulse", SIZE_WORD, b * 4);
  endtask

  initial begin
    rng_state    = 32'd14324;
    value_errors = 0;
    other_errors = 0;
    reset_i      = 1'b1;
    op_valid_i   = 1'b0;
    op_i         = '0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    word_round_trip();
    byte_lane_stores();
    half_lane_stores();
    out_of_range_access();
    fetch_reads();
    busy_pulse_drops();
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/wb_pkg.sv
hdl/lsu_pkg.sv
hdl/wb_lane_steer.sv
hdl/mem_access_unit.sv
hdl/wb_bus_arbiter.sv
hdl/wb_sram_slave.sv
hdl/mem_subsystem_top.sv
verification/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wb_pkg.sv
      - hdl/lsu_pkg.sv
      - hdl/wb_lane_steer.sv
      - hdl/mem_access_unit.sv
      - hdl/wb_bus_arbiter.sv
      - hdl/wb_sram_slave.sv
      - hdl/mem_subsystem_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_mem_subsystem.sv
